// ==== src/mem_pkg.sv ====
package mem_pkg;

  // Default word address width.
  localparam int DEFAULT_ADDRESS_WIDTH = 32;

  // Default data word width.
  localparam int DEFAULT_DATA_WIDTH = 32;

  // Implemented address bits of the word memory.
  // 8 bits give 256 words. Higher address bits are ignored.
  localparam int DEFAULT_MEM_DEPTH_LOG2 = 8;

  // Names the client that owns the current memory access.
  // Also steers the read-valid pulse back to that client.
  typedef enum logic {
    PORT_LSU   = 1'b0,  // Port 1, load/store unit.
    PORT_FETCH = 1'b1   // Port 2, instruction fetch.
  } port_sel_e;

endpackage

// ==== src/mem_port_if.sv ====
`timescale 1ns/1ps

// One client's request bundle toward the shared memory.
// Plain levels only. The client holds req and fields until granted at an edge.
interface mem_port_if
  import mem_pkg::*;
#(
  parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
  parameter int DATA_WIDTH    = DEFAULT_DATA_WIDTH
);

  logic                     req;    // Access wanted.
  logic                     store;  // High for a write, low for a read.
  logic [ADDRESS_WIDTH-1:0] addr;   // Word address.
  logic [DATA_WIDTH-1:0]    wdata;  // Store data.
  logic                     grant;  // Access happens at the next rising edge.

  // Requesting side.
  modport client (
    output req,
    output store,
    output addr,
    output wdata,
    input  grant
  );

  // Arbitrating side.
  modport arbiter (
    input  req,
    input  store,
    input  addr,
    input  wdata,
    output grant
  );

endinterface

// ==== src/arbiter.sv ====
`timescale 1ns/1ps

// Two-client arbiter for the single-ported memory.
// Fetch keeps the memory while it holds req once it has won.
// Otherwise the LSU wins. Grants open only after a falling edge.
module arbiter
  import mem_pkg::*;
#(
  parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
  parameter int DATA_WIDTH    = DEFAULT_DATA_WIDTH
) (
  input  logic                     clk,
  input  logic                     arst_n,
  mem_port_if.arbiter              lsu,        // Port 1.
  mem_port_if.arbiter              fetch,      // Port 2.
  output logic                     mem_req,
  output logic                     mem_store,
  output logic [ADDRESS_WIDTH-1:0] mem_addr,
  output logic [DATA_WIDTH-1:0]    mem_wdata,
  output port_sel_e                mem_sel
);

  logic fetch_hold;  // Fetch won at the last rising edge.
  logic lsu_win;     // LSU win condition, combinational.
  logic fetch_win;   // Fetch win condition, combinational.
  logic lsu_stab;    // LSU condition sampled at the falling edge.
  logic fetch_stab;  // Fetch condition sampled at the falling edge.
  logic lsu_grant;
  logic fetch_grant;

  // Fetch wins on its own, or when it already owns the memory.
  assign fetch_win = fetch.req & (fetch_hold | ~lsu.req);

  // LSU wins unless fetch is holding on.
  assign lsu_win = lsu.req & ~(fetch_hold & fetch.req);

  // Hold register. Remembers that fetch was chosen.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_hold <= 1'b0;
    end else begin
      fetch_hold <= fetch_win;
    end
  end

  // Stabilizers on the falling edge.
  // A condition must stay steady across the low phase start to grant.
  always_ff @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lsu_stab   <= 1'b0;
      fetch_stab <= 1'b0;
    end else begin
      lsu_stab   <= lsu_win;
      fetch_stab <= fetch_win;
    end
  end

  // Grant drops at once with its request.
  assign lsu_grant   = lsu_stab & lsu_win;
  assign fetch_grant = fetch_stab & fetch_win;

  assign lsu.grant   = lsu_grant;
  assign fetch.grant = fetch_grant;

  // Request mux toward memory. LSU fields when it is granted.
  assign mem_req   = lsu_grant | fetch_grant;
  assign mem_store = lsu_grant ? lsu.store : fetch.store;
  assign mem_addr  = lsu_grant ? lsu.addr  : fetch.addr;
  assign mem_wdata = lsu_grant ? lsu.wdata : fetch.wdata;

  // Owner of the access, for routing the read valid.
  assign mem_sel = lsu_grant ? PORT_LSU : PORT_FETCH;

endmodule

// ==== src/main_memory.sv ====
`timescale 1ns/1ps

// Single-ported synchronous word memory.
// Writes at the granted rising edge.
// Reads return one cycle later with a valid pulse for the owning port.
module main_memory
  import mem_pkg::*;
#(
  parameter int ADDRESS_WIDTH  = DEFAULT_ADDRESS_WIDTH,
  parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
  parameter int MEM_DEPTH_LOG2 = DEFAULT_MEM_DEPTH_LOG2
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     mem_req,            // Granted access this cycle.
  input  logic                     mem_store,          // Write when high.
  input  logic [ADDRESS_WIDTH-1:0] mem_addr,
  input  logic [DATA_WIDTH-1:0]    mem_wdata,
  input  port_sel_e                mem_sel,            // Owner of the access.
  output logic [DATA_WIDTH-1:0]    rdata,              // Shared read data bus.
  output logic                     rdata_valid_lsu,    // One-cycle pulse, port 1.
  output logic                     rdata_valid_fetch   // One-cycle pulse, port 2.
);

  localparam int MEM_WORDS = 1 << MEM_DEPTH_LOG2;  // 256 words by default.

  logic [DATA_WIDTH-1:0]     mem [MEM_WORDS];  // Word storage.
  logic [MEM_DEPTH_LOG2-1:0] word_idx;         // Low address bits only.
  logic                      wr_fire;
  logic                      rd_fire;

  // Upper address bits alias onto the same words.
  assign word_idx = mem_addr[MEM_DEPTH_LOG2-1:0];

  assign wr_fire = mem_req & mem_store;
  assign rd_fire = mem_req & ~mem_store;

  // Contents start at zero.
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Write port.
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[word_idx] <= mem_wdata;
    end
  end

  // Read data register. Holds the last word between reads.
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= mem[word_idx];
    end
  end

  // Valid pulses follow the read by one cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata_valid_lsu   <= 1'b0;
      rdata_valid_fetch <= 1'b0;
    end else begin
      rdata_valid_lsu   <= rd_fire & (mem_sel == PORT_LSU);    // Port 1 owns the read.
      rdata_valid_fetch <= rd_fire & (mem_sel == PORT_FETCH);  // Port 2 owns the read.
    end
  end

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps

// Shared memory subsystem top.
// LSU on port 1, instruction fetch on port 2.
// Arbiter picks the owner, main memory does the access.
module mem_subsystem
  import mem_pkg::*;
#(
  parameter int ADDRESS_WIDTH  = DEFAULT_ADDRESS_WIDTH,
  parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
  parameter int MEM_DEPTH_LOG2 = DEFAULT_MEM_DEPTH_LOG2
) (
  input  logic                     clk,
  input  logic                     arst_n,

  // Load/store unit, port 1.
  input  logic                     lsu_req,
  input  logic                     lsu_store,
  input  logic [ADDRESS_WIDTH-1:0] lsu_addr,
  input  logic [DATA_WIDTH-1:0]    lsu_wdata,
  output logic                     lsu_grant,

  // Instruction fetch, port 2.
  input  logic                     fetch_req,
  input  logic                     fetch_store,
  input  logic [ADDRESS_WIDTH-1:0] fetch_addr,
  input  logic [DATA_WIDTH-1:0]    fetch_wdata,
  output logic                     fetch_grant,

  // Read return.
  output logic [DATA_WIDTH-1:0]    rdata,
  output logic                     rdata_valid_lsu,
  output logic                     rdata_valid_fetch
);

  // Memory side of the arbiter.
  logic                     mem_req;
  logic                     mem_store;
  logic [ADDRESS_WIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0]    mem_wdata;
  port_sel_e                mem_sel;

  // Client bundles.
  mem_port_if #(
    .ADDRESS_WIDTH(ADDRESS_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH)
  ) lsu_port ();

  mem_port_if #(
    .ADDRESS_WIDTH(ADDRESS_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH)
  ) fetch_port ();

  // Plain ports into the LSU bundle.
  assign lsu_port.req   = lsu_req;
  assign lsu_port.store = lsu_store;
  assign lsu_port.addr  = lsu_addr;
  assign lsu_port.wdata = lsu_wdata;
  assign lsu_grant      = lsu_port.grant;

  // Plain ports into the fetch bundle.
  assign fetch_port.req   = fetch_req;
  assign fetch_port.store = fetch_store;
  assign fetch_port.addr  = fetch_addr;
  assign fetch_port.wdata = fetch_wdata;
  assign fetch_grant      = fetch_port.grant;

  arbiter #(
    .ADDRESS_WIDTH(ADDRESS_WIDTH),
    .DATA_WIDTH   (DATA_WIDTH)
  ) i_arbiter (
    .clk      (clk),
    .arst_n   (arst_n),
    .lsu      (lsu_port),    // Port 1 has default priority.
    .fetch    (fetch_port),  // Port 2 holds once it wins.
    .mem_req  (mem_req),
    .mem_store(mem_store),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_sel  (mem_sel)
  );

  main_memory #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .DATA_WIDTH    (DATA_WIDTH),
    .MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)
  ) i_main_memory (
    .clk              (clk),
    .arst_n           (arst_n),
    .mem_req          (mem_req),
    .mem_store        (mem_store),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata),
    .mem_sel          (mem_sel),
    .rdata            (rdata),
    .rdata_valid_lsu  (rdata_valid_lsu),
    .rdata_valid_fetch(rdata_valid_fetch)
  );

endmodule

// ==== tb/mem_checker.sv ====
`timescale 1ns/1ps

// Watches every DUT port and compares it against a word model.
// Samples 1 ns ahead of each rising edge.
// Grants are also checked 1 ns ahead of each falling edge.
module mem_checker
  import mem_pkg::*;
#(
  parameter int ADDRESS_WIDTH  = DEFAULT_ADDRESS_WIDTH,
  parameter int DATA_WIDTH     = DEFAULT_DATA_WIDTH,
  parameter int MEM_DEPTH_LOG2 = DEFAULT_MEM_DEPTH_LOG2
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     lsu_req,
  input  logic                     lsu_store,
  input  logic [ADDRESS_WIDTH-1:0] lsu_addr,
  input  logic [DATA_WIDTH-1:0]    lsu_wdata,
  input  logic                     lsu_grant,
  input  logic                     fetch_req,
  input  logic                     fetch_store,
  input  logic [ADDRESS_WIDTH-1:0] fetch_addr,
  input  logic [DATA_WIDTH-1:0]    fetch_wdata,
  input  logic                     fetch_grant,
  input  logic [DATA_WIDTH-1:0]    rdata,
  input  logic                     rdata_valid_lsu,
  input  logic                     rdata_valid_fetch,
  output int                       error_count
);

  logic [DATA_WIDTH-1:0] ref_mem [1 << MEM_DEPTH_LOG2];  // Model words.
  logic                  fetch_held;       // Fetch owned the previous edge.
  logic [1:0]            fall_win;         // Win condition across the last falling edge.
  logic                  exp_valid_lsu;    // Read by LSU at the previous edge.
  logic                  exp_valid_fetch;
  logic [DATA_WIDTH-1:0] exp_rdata;

  // Winner of the coming edge. Bit 0 LSU, bit 1 fetch.
  function automatic logic [1:0] expected_grant(input logic l_req, input logic f_req,
                                                input logic held);
    if (f_req && held) return 2'b10;  // Fetch keeps what it has.
    if (l_req) return 2'b01;          // LSU first otherwise.
    if (f_req) return 2'b10;
    return 2'b00;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s expected %0b, actual %0b", $time, name, exp, act);
    end
  endtask

  task automatic report(input string msg);
    error_count++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // Apply one access to the model. Upper address bits alias.
  task automatic apply_access(input logic st, input logic [ADDRESS_WIDTH-1:0] a,
                              input logic [DATA_WIDTH-1:0] d, output logic rd);
    logic [MEM_DEPTH_LOG2-1:0] idx;
    idx = a[MEM_DEPTH_LOG2-1:0];
    rd  = ~st;
    if (st) ref_mem[idx] = d;
    else exp_rdata = ref_mem[idx];
  endtask

  initial begin
    logic [1:0] win;
    logic [1:0] early;  // Grants due in the high phase.
    error_count     = 0;
    fetch_held      = 1'b0;
    fall_win        = 2'b00;
    exp_valid_lsu   = 1'b0;
    exp_valid_fetch = 1'b0;
    exp_rdata       = '0;
    foreach (ref_mem[i]) ref_mem[i] = '0;  // Memory starts cleared.
    forever begin
      @(posedge clk);
      #3;  // High phase, inputs settled.
      if (arst_n) begin
        // A new winner has no grant until a falling edge has passed.
        early = expected_grant(lsu_req, fetch_req, fetch_held) & fall_win;
        check_bit("lsu_grant", early[0], lsu_grant);
        check_bit("fetch_grant", early[1], fetch_grant);
      end
      @(negedge clk);
      #3;
      if (!arst_n) begin
        fetch_held      = 1'b0;
        fall_win        = 2'b00;
        exp_valid_lsu   = 1'b0;
        exp_valid_fetch = 1'b0;
      end else begin
        win = expected_grant(lsu_req, fetch_req, fetch_held);
        check_bit("lsu_grant", win[0], lsu_grant);
        check_bit("fetch_grant", win[1], fetch_grant);
        if (lsu_grant && fetch_grant) report("both grants are high together");
        if (lsu_grant && !lsu_req) report("lsu_grant is high without lsu_req");
        if (fetch_grant && !fetch_req) report("fetch_grant is high without fetch_req");
        check_bit("rdata_valid_lsu", exp_valid_lsu, rdata_valid_lsu);
        check_bit("rdata_valid_fetch", exp_valid_fetch, rdata_valid_fetch);
        if ((exp_valid_lsu || exp_valid_fetch) && rdata !== exp_rdata) begin
          error_count++;
          $display("mismatch at %0t: rdata expected %0h, actual %0h", $time, exp_rdata, rdata);
        end
        exp_valid_lsu   = 1'b0;
        exp_valid_fetch = 1'b0;
        if (win[0]) apply_access(lsu_store, lsu_addr, lsu_wdata, exp_valid_lsu);
        else if (win[1]) apply_access(fetch_store, fetch_addr, fetch_wdata, exp_valid_fetch);
        fetch_held = win[1];  // Hold flop loads at this edge.
        fall_win   = win;     // Held steady across the falling edge just passed.
      end
    end
  end

endmodule

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

// Testbench top. Two client processes share the memory through the DUT.
module tb_mem_subsystem
  import mem_pkg::*;
();

  localparam int AW = DEFAULT_ADDRESS_WIDTH;
  localparam int DW = DEFAULT_DATA_WIDTH;
  localparam int DL = DEFAULT_MEM_DEPTH_LOG2;

  logic          clk;
  logic          arst_n;
  logic          lsu_req;
  logic          lsu_store;
  logic [AW-1:0] lsu_addr;
  logic [DW-1:0] lsu_wdata;
  logic          lsu_grant;
  logic          fetch_req;
  logic          fetch_store;
  logic [AW-1:0] fetch_addr;
  logic [DW-1:0] fetch_wdata;
  logic          fetch_grant;
  logic [DW-1:0] rdata;
  logic          rdata_valid_lsu;
  logic          rdata_valid_fetch;
  int            checker_errors;  // Counted by the checker.
  int            timeout_count;   // Waits that gave up.

  mem_subsystem #(
    .ADDRESS_WIDTH (AW),
    .DATA_WIDTH    (DW),
    .MEM_DEPTH_LOG2(DL)
  ) i_dut (.*);

  mem_checker #(
    .ADDRESS_WIDTH (AW),
    .DATA_WIDTH    (DW),
    .MEM_DEPTH_LOG2(DL)
  ) i_checker (.*, .error_count(checker_errors));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  // Plain 32-bit LCG.
  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Wait for the next rising edge plus the drive offset.
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic release_req(input bit fp);
    if (fp) fetch_req = 1'b0;
    else lsu_req = 1'b0;
  endtask

  // Raise req with its fields and hold them until a grant is seen.
  // Returns just after the edge where the access happened.
  task automatic access(input bit fp, input logic st, input logic [AW-1:0] a,
                        input logic [DW-1:0] d);
    bit seen;
    int n;
    seen = 1'b0;
    if (fp) begin
      fetch_req   = 1'b1;
      fetch_store = st;
      fetch_addr  = a;
      fetch_wdata = d;
    end else begin
      lsu_req   = 1'b1;
      lsu_store = st;
      lsu_addr  = a;
      lsu_wdata = d;
    end
    for (n = 0; n < 50 && !seen; n++) begin
      @(negedge clk);
      #3;  // Grant is settled just before the edge.
      seen = fp ? fetch_grant : lsu_grant;
    end
    if (!seen) begin
      timeout_count++;
      $display("%0t: %s grant did not arrive within 50 cycles", $time, fp ? "fetch" : "lsu");
    end
    idle(1);
  endtask

  // Read valid is expected in the cycle right after the granted edge.
  task automatic wait_valid(input bit fp);
    bit seen;
    int n;
    seen = 1'b0;
    for (n = 0; n < 50 && !seen; n++) begin
      @(negedge clk);
      #3;
      seen = fp ? rdata_valid_fetch : rdata_valid_lsu;
    end
    if (!seen) begin
      timeout_count++;
      $display("%0t: %s read valid did not arrive within 50 cycles", $time,
               fp ? "fetch" : "lsu");
    end
    idle(1);
  endtask

  // Random accesses and idle gaps for one client.
  task automatic random_traffic(input bit fp, input int count);
    int unsigned seed;
    int unsigned r;
    logic [DW-1:0] d;
    int gap;
    int i;
    seed = 32'd12;
    if (fp) seed = lcg_next(seed);  // Fetch runs one draw ahead.
    for (i = 0; i < count; i++) begin
      seed = lcg_next(seed);
      r    = seed >> 8;  // Drop the weak low bits.
      seed = lcg_next(seed);
      d    = DW'(seed);
      if (fp) begin
        access(1'b1, r[13:12] == 2'b00, AW'({r[23:20], 18'h0, r[9:0]}), d);  // Mostly reads.
        gap = r[15] ? 0 : int'(r[14:13]);  // Long back-to-back runs hold the memory.
      end else begin
        access(1'b0, r[12], AW'({r[23:20], 18'h0, r[9:0]}), d);
        gap = int'(r[15:14]);
      end
      if (gap != 0) begin
        release_req(fp);
        idle(gap);
      end
    end
    release_req(fp);
  endtask

  initial begin
    int k;
    int i;
    arst_n        = 1'b0;
    timeout_count = 0;
    lsu_req       = 1'b0;
    lsu_store     = 1'b0;
    lsu_addr      = '0;
    lsu_wdata     = '0;
    fetch_req     = 1'b0;
    fetch_store   = 1'b0;
    fetch_addr    = '0;
    fetch_wdata   = '0;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    idle(4);  // Outputs stay quiet.

    // LSU writes, then reads back. 0x110 aliases 0x10.
    access(1'b0, 1'b1, 32'h0000_0010, 32'hcafe_0001);
    access(1'b0, 1'b1, 32'h0000_0024, 32'hcafe_0002);
    access(1'b0, 1'b1, 32'h0000_0110, 32'hcafe_0003);
    release_req(1'b0);
    access(1'b0, 1'b0, 32'h0000_0010, '0);
    release_req(1'b0);
    wait_valid(1'b0);
    access(1'b0, 1'b0, 32'h0000_0024, '0);
    release_req(1'b0);
    wait_valid(1'b0);

    // Same from the fetch side.
    access(1'b1, 1'b1, 32'h0000_0030, 32'hbeef_0001);
    access(1'b1, 1'b1, 32'h0000_1030, 32'hbeef_0002);
    release_req(1'b1);
    access(1'b1, 1'b0, 32'h0000_0030, '0);
    release_req(1'b1);
    wait_valid(1'b1);
    idle(2);

    // Both request with no fetch hold. LSU goes first.
    fork
      begin
        access(1'b0, 1'b1, 32'h0000_0040, 32'h1234_5678);
        release_req(1'b0);
      end
      begin
        access(1'b1, 1'b0, 32'h0000_0040, '0);
        release_req(1'b1);
      end
    join
    idle(2);

    // Fetch holds across back-to-back stores while the LSU waits.
    fork
      begin
        for (k = 0; k < 5; k++) begin
          access(1'b1, 1'b1, 32'h0000_0200 + k, 32'h5a5a_0000 + k);
        end
        release_req(1'b1);
      end
      begin
        idle(2);
        access(1'b0, 1'b1, 32'h0000_0200, 32'ha5a5_ffff);  // Served after fetch drops.
        release_req(1'b0);
      end
    join
    idle(2);

    fork
      random_traffic(1'b0, 400);
      random_traffic(1'b1, 400);
    join
    idle(3);

    // Final sweep. Every word is compared with the model.
    for (i = 0; i < 2 ** DL; i++) begin
      access(1'b0, 1'b0, AW'(i), '0);
      release_req(1'b0);
      wait_valid(1'b0);
    end
    idle(3);

    $display("checker errors %0d, timeouts %0d", checker_errors, timeout_count);
    if (checker_errors == 0 && timeout_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/mem_pkg.sv
src/mem_port_if.sv
src/arbiter.sv
src/main_memory.sv
src/mem_subsystem.sv
tb/mem_checker.sv
tb/tb_mem_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass line shows up.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mem_subsystem -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "All tests passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: build or simulation failed"; exit 1; }
